/* include/sap_macros.svh */
`ifndef SAP_MACROS_SVH
`define SAP_MACROS_SVH

// Width of every data word, register and memory byte
`define SAP_DATA_W 8

// Program memory address width
`define SAP_ADDR_W 4

// Opcode field in the upper nibble of an instruction
`define SAP_OP_W 4

// Number of program memory words
`define SAP_RAM_DEPTH 16

// T-states per instruction
`define SAP_T_STATES 4

`endif

/* logic/programRam.sv */
`include "sap_macros.svh"

module programRam
    import sapIsaPkg::*;
    import sapCtrlPkg::*;
(
    input  logic      clk,
    input  logic      run,
    input  progLoad_t progLoad,
    input  addr_t     ramAddr,
    output data_t     ramData,
    output data_t     progData
);

    // 16 program bytes, kept across CLR
    data_t [`SAP_RAM_DEPTH-1:0] mem;

    // Program mode write only
    always_ff @(posedge clk)
    begin
        if (progLoad.strobe && !run)
        begin
            mem[progLoad.addr] <= progLoad.data;
        end
    end

    // Execution read
    assign ramData = mem[ramAddr];

    // Monitor read of the switch address
    assign progData = mem[progLoad.addr];

    // Program stays fixed once the machine runs
    assert property (@(posedge clk) run |=> $stable(mem));

endmodule

/* logic/sapCtrlPkg.sv */
`include "sap_macros.svh"

package sapCtrlPkg;

    import sapIsaPkg::*;

    // Four-step instruction cycle
    typedef enum logic [$clog2(`SAP_T_STATES)-1:0]
    {
        T1,
        T2,
        T3,
        T4
    } tState_t;

    // Datapath controls issued by the sequencer
    typedef struct packed
    {
        // Accumulator takes the memory byte
        logic accLoadMem;
        // Register B takes the memory byte
        logic bLoad;
        // Accumulator takes the ALU result
        logic accLoadAlu;
        // ALU subtracts B instead of adding
        logic subtract;
        // Output register takes the accumulator
        logic outLoad;
    } ctrlWord_t;

    // Program mode write from the switches
    typedef struct packed
    {
        addr_t addr;
        data_t data;
        logic  strobe;
    } progLoad_t;

endpackage

/* logic/sapDatapath.sv */
module sapDatapath
    import sapIsaPkg::*;
    import sapCtrlPkg::*;
(
    input  logic      clk,
    input  logic      CLR,
    input  ctrlWord_t ctrl,
    input  data_t     ramData,
    output data_t     outValue,
    output logic      outStrobe
);

    data_t accReg;
    data_t regB;
    data_t aluResult;

    // Modulo-256 add or subtract
    assign aluResult = ctrl.subtract ? (accReg - regB) : (accReg + regB);

    // Accumulator from memory or ALU
    always_ff @(posedge clk or posedge CLR)
    begin
        if (CLR)
        begin
            accReg <= '0;
        end
        else if (ctrl.accLoadMem)
        begin
            accReg <= ramData;
        end
        else if (ctrl.accLoadAlu)
        begin
            accReg <= aluResult;
        end
    end

    // B operand for ADD and SUB
    always_ff @(posedge clk or posedge CLR)
    begin
        if (CLR)
        begin
            regB <= '0;
        end
        else if (ctrl.bLoad)
        begin
            regB <= ramData;
        end
    end

    // Output register and its strobe
    always_ff @(posedge clk or posedge CLR)
    begin
        if (CLR)
        begin
            outValue  <= '0;
            outStrobe <= 1'b0;
        end
        else
        begin
            // High for the one cycle after the OUT load
            outStrobe <= ctrl.outLoad;
            if (ctrl.outLoad)
            begin
                outValue <= accReg;
            end
        end
    end

    // OUT loads are always four cycles apart at least
    assert property (@(posedge clk) disable iff (CLR)
        outStrobe |=> !outStrobe);

endmodule

/* logic/sapIsaPkg.sv */
`include "sap_macros.svh"

package sapIsaPkg;

    // Basic machine words
    typedef logic [`SAP_DATA_W-1:0] data_t;
    typedef logic [`SAP_ADDR_W-1:0] addr_t;

    // Instruction set, anything else runs as a no-operation
    typedef enum logic [`SAP_OP_W-1:0]
    {
        OP_LDA = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_OUT = 4'd14,
        OP_HLT = 4'd15
    } opcode_t;

    // Opcode in the high nibble, operand address in the low nibble
    typedef struct packed
    {
        opcode_t opcode;
        addr_t   operand;
    } instr_t;

endpackage

/* logic/sapSequencer.sv */
module sapSequencer
    import sapIsaPkg::*;
    import sapCtrlPkg::*;
(
    input  logic      clk,
    input  logic      CLR,
    input  logic      run,
    input  data_t     ramData,
    output addr_t     ramAddr,
    output ctrlWord_t ctrl,
    output logic      halted
);

    tState_t tState;
    tState_t nextState;
    addr_t   progCounter;
    instr_t  instrReg;
    logic    advance;

    // Machine steps only while running and not halted
    assign advance = run && !halted;

    always_comb
    begin
        case (tState)
            T1:      nextState = T2;
            T2:      nextState = T3;
            T3:      nextState = T4;
            default: nextState = T1;
        endcase
    end

    always_ff @(posedge clk or posedge CLR)
    begin
        if (CLR)
        begin
            tState <= T1;
        end
        else if (advance)
        begin
            tState <= nextState;
        end
    end

    // Fetch at T1, increment at T2
    always_ff @(posedge clk or posedge CLR)
    begin
        if (CLR)
        begin
            progCounter <= '0;
            instrReg    <= '0;
        end
        else if (advance)
        begin
            if (tState == T1)
            begin
                instrReg <= instr_t'(ramData);
            end
            if (tState == T2)
            begin
                // Wraps from 15 back to 0
                progCounter <= progCounter + 1'b1;
            end
        end
    end

    // Halt is sticky until CLR
    always_ff @(posedge clk or posedge CLR)
    begin
        if (CLR)
        begin
            halted <= 1'b0;
        end
        else if (advance && tState == T3 && instrReg.opcode == OP_HLT)
        begin
            halted <= 1'b1;
        end
    end

    // Program counter drives memory during fetch, operand otherwise
    assign ramAddr = (tState == T1) ? progCounter : instrReg.operand;

    // Control decode
    always_comb
    begin
        ctrl = '0;
        if (advance)
        begin
            case (tState)
                T3:
                begin
                    case (instrReg.opcode)
                        OP_LDA:  ctrl.accLoadMem = 1'b1;
                        OP_ADD:  ctrl.bLoad      = 1'b1;
                        OP_SUB:  ctrl.bLoad      = 1'b1;
                        OP_OUT:  ctrl.outLoad    = 1'b1;
                        default: ctrl = '0;
                    endcase
                end
                T4:
                begin
                    case (instrReg.opcode)
                        OP_ADD:
                        begin
                            ctrl.accLoadAlu = 1'b1;
                        end
                        OP_SUB:
                        begin
                            ctrl.accLoadAlu = 1'b1;
                            ctrl.subtract   = 1'b1;
                        end
                        default: ctrl = '0;
                    endcase
                end
                default: ctrl = '0;
            endcase
        end
    end

    // Datapath never sees two register loads in one cycle
    assert property (@(posedge clk) disable iff (CLR)
        $onehot0({ctrl.accLoadMem, ctrl.bLoad, ctrl.accLoadAlu, ctrl.outLoad}));

    // Paused or halted machine issues nothing
    assert property (@(posedge clk) disable iff (CLR)
        (halted || !run) |-> (ctrl == '0));

endmodule

/* logic/sapTop.sv */
module sapTop
    import sapIsaPkg::*;
    import sapCtrlPkg::*;
(
    input  logic  clk,
    input  logic  CLR,
    input  logic  run,
    input  logic  loadStrobe,
    input  addr_t loadAddr,
    input  data_t loadData,
    output data_t progData,
    output data_t outValue,
    output logic  outStrobe,
    output logic  halted
);

    progLoad_t progLoad;
    addr_t     ramAddr;
    data_t     ramData;
    ctrlWord_t ctrl;

    // Switch inputs bundled for the memory load port
    assign progLoad = '{addr: loadAddr, data: loadData, strobe: loadStrobe};

    sapSequencer sequencer
    (
        .clk     (clk),
        .CLR     (CLR),
        .run     (run),
        .ramData (ramData),
        .ramAddr (ramAddr),
        .ctrl    (ctrl),
        .halted  (halted)
    );

    programRam ram
    (
        .clk      (clk),
        .run      (run),
        .progLoad (progLoad),
        .ramAddr  (ramAddr),
        .ramData  (ramData),
        .progData (progData)
    );

    // Accumulator, B, ALU and output register
    sapDatapath datapath
    (
        .clk       (clk),
        .CLR       (CLR),
        .ctrl      (ctrl),
        .ramData   (ramData),
        .outValue  (outValue),
        .outStrobe (outStrobe)
    );

endmodule

/* run.sh */
#!/bin/sh
# Builds the SAP testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f src.f \
    --top-module sapTb \
    -Mdir obj_dir \
    -o sapSim

# Exit status is nonzero when the testbench stops with a failure
./obj_dir/sapSim

/* src.f */
+incdir+include
logic/sapIsaPkg.sv
logic/sapCtrlPkg.sv
logic/sapSequencer.sv
logic/programRam.sv
logic/sapDatapath.sv
logic/sapTop.sv
verif/sapTb.sv

/* verif/sapTb.sv */
`include "sap_macros.svh"

module sapTb
    import sapIsaPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Tests need roughly 900 cycles
    localparam int cycleLimit = 3000;

    logic  clk;
    logic  CLR;
    logic  run;
    logic  loadStrobe;
    addr_t loadAddr;
    data_t loadData;
    data_t progData;
    data_t outValue;
    logic  outStrobe;
    logic  halted;

    // Reference model: program image and expected results
    data_t image [`SAP_RAM_DEPTH];
    data_t expVals [$];
    int    expTimes [$];
    int    expHaltCycle;

    logic [31:0] lcgState;
    int          cycleCount;

    sapTop UUT
    (
        .clk        (clk),
        .CLR        (CLR),
        .run        (run),
        .loadStrobe (loadStrobe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .progData   (progData),
        .outValue   (outValue),
        .outStrobe  (outStrobe),
        .halted     (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            failRun("Timeout: the tests did not finish within the cycle limit");
        end
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic data_t makeInstr(input opcode_t op, input addr_t operand);
        return {op, operand};
    endfunction

    function automatic void clearImage();
        for (int i = 0; i < `SAP_RAM_DEPTH; i++)
        begin
            image[addr_t'(i)] = 8'h00;
        end
    endfunction

    // Executes the image by the ISA rules, four cycles per instruction
    function automatic void modelRun();
        data_t acc;
        data_t ir;
        addr_t pc;
        addr_t operand;
        expVals.delete();
        expTimes.delete();
        expHaltCycle = -1;
        acc = 8'h00;
        pc = 4'd0;
        for (int k = 0; k < 64; k++)
        begin
            ir = image[pc];
            operand = ir[3:0];
            pc = pc + 1'b1;
            case (ir[7:4])
                OP_LDA: acc = image[operand];
                OP_ADD: acc = acc + image[operand];
                OP_SUB: acc = acc - image[operand];
                OP_OUT:
                begin
                    // Strobe seen in the cycle after the T3 edge
                    expVals.push_back(acc);
                    expTimes.push_back(4 * k + 2);
                end
                OP_HLT:
                begin
                    expHaltCycle = 4 * k + 2;
                    break;
                end
                default: ;
            endcase
        end
    endfunction

    task automatic failRun(input string reason);
        $display("Checks failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkData(input string testName, input data_t expected, input data_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", testName, expected, actual);
            failRun("A data value did not match the reference model");
        end
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %b, actual %b", testName, expected, actual);
            failRun("A flag did not match the reference model");
        end
    endtask

    task automatic resetMachine();
        @(negedge clk);
        CLR = 1'b1;
        run = 1'b0;
        loadStrobe = 1'b0;
        repeat (4) @(negedge clk);
        CLR = 1'b0;
    endtask

    task automatic writeByte(input addr_t addr, input data_t data);
        @(negedge clk);
        loadAddr = addr;
        loadData = data;
        loadStrobe = 1'b1;
        @(negedge clk);
        loadStrobe = 1'b0;
    endtask

    task automatic loadImage();
        for (int i = 0; i < `SAP_RAM_DEPTH; i++)
        begin
            writeByte(addr_t'(i), image[addr_t'(i)]);
        end
    endtask

    task automatic readByte(input addr_t addr);
        @(negedge clk);
        loadAddr = addr;
        @(negedge clk);
        checkData("program load readback", image[addr], progData);
    endtask

    // Runs until halted, comparing strobes and halt with the model every cycle
    task automatic runProgram(input string testName, input int expGap);
        int   n;
        int   lastStrobe;
        logic expStrobe;
        modelRun();
        if (expHaltCycle < 0)
        begin
            failRun("The reference program never reaches HLT");
        end
        n = 0;
        lastStrobe = -1;
        @(negedge clk);
        run = 1'b1;
        do
        begin
            @(negedge clk);
            // Spacing measured between the strobes the DUT gives
            if (outStrobe === 1'b1)
            begin
                if (expGap > 0 && lastStrobe >= 0)
                begin
                    checkFlag({testName, " strobe spacing"}, 1'b1, (n - lastStrobe) == expGap);
                end
                lastStrobe = n;
            end
            expStrobe = (expTimes.size() > 0) && (expTimes[0] == n);
            checkFlag({testName, " outStrobe"}, expStrobe, outStrobe);
            if (expStrobe)
            begin
                checkData({testName, " outValue"}, expVals[0], outValue);
                void'(expVals.pop_front());
                void'(expTimes.pop_front());
            end
            checkFlag({testName, " halted"}, n >= expHaltCycle, halted);
            n++;
        end
        while (!halted && n <= expHaltCycle + 4);
        if (expVals.size() != 0)
        begin
            failRun("The machine halted before giving every expected output");
        end
    endtask

    task automatic watchIdle(input string testName, input int cycles);
        data_t held;
        held = outValue;
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            checkFlag({testName, " outStrobe"}, 1'b0, outStrobe);
            checkFlag({testName, " halted"}, 1'b1, halted);
            checkData({testName, " outValue"}, held, outValue);
        end
    endtask

    task automatic loadAndReadBack();
        logic [31:0] r;
        for (int i = 0; i < `SAP_RAM_DEPTH; i++)
        begin
            r = lcgNext();
            image[addr_t'(i)] = r[23:16];
        end
        loadImage();
        for (int i = 0; i < `SAP_RAM_DEPTH; i++)
        begin
            readByte(addr_t'(i));
        end
        // Load port is ignored in run mode
        @(negedge clk);
        run = 1'b1;
        loadAddr = 4'd9;
        loadData = ~image[4'd9];
        loadStrobe = 1'b1;
        @(negedge clk);
        checkData("write blocked in run mode", image[4'd9], progData);
        loadStrobe = 1'b0;
        run = 1'b0;
        @(negedge clk);
        checkData("write blocked in run mode", image[4'd9], progData);
    endtask

    task automatic ldaOutProgram();
        logic [31:0] r;
        r = lcgNext();
        clearImage();
        image[4'd0] = makeInstr(OP_LDA, 4'd14);
        image[4'd1] = makeInstr(OP_OUT, 4'd0);
        image[4'd2] = makeInstr(OP_HLT, 4'd0);
        image[4'd14] = r[23:16];
        resetMachine();
        loadImage();
        runProgram("LDA and OUT", 0);
    endtask

    task automatic addSubWrap();
        clearImage();
        image[4'd0] = makeInstr(OP_LDA, 4'd13);
        image[4'd1] = makeInstr(OP_ADD, 4'd14);
        image[4'd2] = makeInstr(OP_OUT, 4'd0);
        image[4'd3] = makeInstr(OP_SUB, 4'd15);
        image[4'd4] = makeInstr(OP_OUT, 4'd0);
        image[4'd5] = makeInstr(OP_HLT, 4'd0);
        // 200 + 100 overflows, then 44 - 80 underflows
        image[4'd13] = 8'd200;
        image[4'd14] = 8'd100;
        image[4'd15] = 8'd80;
        resetMachine();
        loadImage();
        runProgram("ADD and SUB wrap", 0);
    endtask

    task automatic haltAndNop();
        clearImage();
        image[4'd0] = makeInstr(OP_LDA, 4'd14);
        image[4'd1] = 8'h5F;
        image[4'd2] = makeInstr(OP_OUT, 4'd0);
        image[4'd3] = 8'h3F;
        image[4'd4] = makeInstr(OP_HLT, 4'd0);
        // Never reached once halted
        image[4'd5] = makeInstr(OP_OUT, 4'd0);
        image[4'd6] = makeInstr(OP_ADD, 4'd15);
        image[4'd14] = 8'h42;
        image[4'd15] = 8'h17;
        resetMachine();
        loadImage();
        runProgram("halt and no-operation", 0);
        watchIdle("after HLT", 40);
    endtask

    task automatic clearAndRerun();
        clearImage();
        image[4'd0] = makeInstr(OP_LDA, 4'd12);
        image[4'd1] = makeInstr(OP_SUB, 4'd13);
        image[4'd2] = makeInstr(OP_OUT, 4'd0);
        image[4'd3] = makeInstr(OP_ADD, 4'd14);
        image[4'd4] = makeInstr(OP_OUT, 4'd0);
        image[4'd5] = makeInstr(OP_HLT, 4'd0);
        image[4'd12] = 8'h35;
        image[4'd13] = 8'h90;
        image[4'd14] = 8'h20;
        resetMachine();
        loadImage();
        runProgram("first run", 0);
        resetMachine();
        checkData("CLR outValue", 8'h00, outValue);
        checkFlag("CLR halted", 1'b0, halted);
        // Memory is not reloaded here
        runProgram("re-run after CLR", 0);
    endtask

    task automatic randomPrograms();
        logic [31:0] r;
        for (int p = 0; p < 6; p++)
        begin
            clearImage();
            image[4'd0] = makeInstr(OP_LDA, 4'd11);
            for (int i = 0; i < 4; i++)
            begin
                r = lcgNext();
                image[addr_t'(2 * i + 1)] = makeInstr(r[27] ? OP_SUB : OP_ADD, addr_t'(12 + i));
                image[addr_t'(2 * i + 2)] = makeInstr(OP_OUT, 4'd0);
            end
            image[4'd9] = makeInstr(OP_HLT, 4'd0);
            for (int i = 10; i < `SAP_RAM_DEPTH; i++)
            begin
                r = lcgNext();
                image[addr_t'(i)] = r[23:16];
            end
            resetMachine();
            loadImage();
            runProgram("random program", 8);
        end
    endtask

    initial
    begin
        CLR = 1'b1;
        run = 1'b0;
        loadStrobe = 1'b0;
        loadAddr = 4'd0;
        loadData = 8'h00;
        lcgState = 32'd96290;
        cycleCount = 0;
        resetMachine();
        loadAndReadBack();
        ldaOutProgram();
        addSubWrap();
        haltAndNop();
        clearAndRerun();
        randomPrograms();
        $display("All checks passed");
        $finish;
    end

endmodule
